/* include/teller_defines.svh */
// Teller build constants

`ifndef TELLER_DEFINES_SVH
`define TELLER_DEFINES_SVH

// Accounts in the ledger, also the table size
`define LEDGER_ACCOUNTS 8

// Secret table rule: entry i = i * TABLE_MULT + TABLE_ADD, mod 256
`define TABLE_MULT 37
`define TABLE_ADD 11

// Every account holds this much after reset
`define START_BALANCE 100

// Length of the travel animation in cycles
`define TRAVEL_LEN 8

// Button synchroniser depth
`define KEY_SYNC_STAGES 2

`endif

/* logic/teller_pkg.sv */
// Teller shared types

`include "teller_defines.svh"

package teller_pkg;

	// Account number width follows the ledger size
	localparam int ACCOUNT_W = $clog2(`LEDGER_ACCOUNTS);

	// Key view of the switches, pin tag over account number
	typedef struct packed {
		logic [7-ACCOUNT_W:0] pin;
		logic [ACCOUNT_W-1:0] account;
	} key_view_t;

	// One switch word, read as an amount or as a key
	typedef union packed {
		logic [7:0] amount;
		key_view_t key;
	} sw_word_u;

	// Transaction steps
	typedef enum logic [2:0] {
		STEP_IDLE,
		STEP_FETCH_TABLE,
		STEP_FETCH_BAL,
		STEP_CHECK,
		STEP_WRITE,
		STEP_TRAVEL,
		STEP_DONE
	} step_e;

	// RAM access kinds
	typedef enum logic [1:0] {
		ACC_TABLE,
		ACC_LEDGER_RD,
		ACC_LEDGER_WR
	} access_e;

endpackage

/* logic/ledger_mem_if.sv */
// Ledger RAM access bundle

`timescale 1ns/10ps

interface ledger_mem_if;

	teller_pkg::access_e access;
	logic [teller_pkg::ACCOUNT_W-1:0] index;
	logic [7:0] wdata;
	logic wren;
	// Word addressed in the previous cycle
	logic [7:0] rdata;

	modport controller (
		output access,
		output index,
		output wdata,
		output wren,
		input rdata
	);

	modport ram (
		input access,
		input index,
		input wdata,
		input wren,
		output rdata
	);

	// Datapath only watches the read side
	modport monitor (
		input access,
		input rdata
	);

endinterface

/* logic/main_control.sv */
// Button and load control

`timescale 1ns/10ps

`include "teller_defines.svh"

module main_control (
	input logic clock,
	input logic rst_n,
	input logic [1:0] key_n,
	input logic [7:0] sw,
	input logic finished,
	output logic start,
	output teller_pkg::sw_word_u amount,
	output teller_pkg::sw_word_u key,
	output logic [teller_pkg::ACCOUNT_W-1:0] account,
	output logic busy,
	output logic ready
);

	localparam int SYNC_N = `KEY_SYNC_STAGES;

	typedef enum logic [1:0] {
		WAIT_AMOUNT,
		WAIT_KEY,
		READY,
		BUSY
	} state_e;

	state_e state_q;
	logic [1:0] sync_q [SYNC_N];
	logic [1:0] key_d;
	logic [1:0] press;
	logic start_press;
	logic load_press;

	// Buttons idle high
	always_ff @(posedge clock or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < SYNC_N; i++)
				sync_q[i] <= 2'b11;
			key_d <= 2'b11;
		end
		else
		begin
			sync_q[0] <= key_n;
			for (int i = 1; i < SYNC_N; i++)
				sync_q[i] <= sync_q[i-1];
			key_d <= sync_q[SYNC_N-1];
		end
	end

	// Falling edge of the synchronised level
	assign press = key_d & ~sync_q[SYNC_N-1];
	assign start_press = press[0];
	assign load_press = press[1];

	always_ff @(posedge clock or negedge rst_n)
	begin
		if (!rst_n)
			state_q <= WAIT_AMOUNT;
		else
		begin
			case (state_q)
				WAIT_AMOUNT:
				begin
					if (load_press)
						state_q <= WAIT_KEY;
				end
				WAIT_KEY:
				begin
					if (load_press)
						state_q <= READY;
				end
				// A new load here starts over with the amount
				READY:
				begin
					if (start_press)
						state_q <= BUSY;
					else if (load_press)
						state_q <= WAIT_KEY;
				end
				BUSY:
				begin
					if (finished)
						state_q <= WAIT_AMOUNT;
				end
				default: state_q <= WAIT_AMOUNT;
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if (load_press && (state_q == WAIT_AMOUNT || (state_q == READY && !start_press)))
			amount <= teller_pkg::sw_word_u'(sw);
		if (load_press && state_q == WAIT_KEY)
			key <= teller_pkg::sw_word_u'(sw);
	end

	assign ready = (state_q == READY);
	assign busy = (state_q == BUSY);
	assign start = start_press && ready;
	assign account = key.key.account;

	// Operands hold while a transaction runs
	operands_held: assert property (@(posedge clock) disable iff (!rst_n)
		busy |=> $stable(amount) && $stable(key));

endmodule

/* logic/transaction_control.sv */
// Transaction step sequencer

`timescale 1ns/10ps

`include "teller_defines.svh"

module transaction_control (
	input logic clock,
	input logic rst_n,
	input logic start,
	input logic [teller_pkg::ACCOUNT_W-1:0] account,
	input logic check_done,
	input logic approved,
	input logic [7:0] new_balance,
	ledger_mem_if.controller mem,
	output teller_pkg::step_e step,
	output logic [2:0] travel,
	output logic finished
);

	localparam logic [2:0] TRAVEL_LAST = 3'(`TRAVEL_LEN - 1);

	teller_pkg::step_e step_q;
	logic [2:0] cnt_q;
	logic [teller_pkg::ACCOUNT_W-1:0] account_q;

	always_ff @(posedge clock or negedge rst_n)
	begin
		if (!rst_n)
		begin
			step_q <= teller_pkg::STEP_IDLE;
			cnt_q <= '0;
			account_q <= '0;
		end
		else
		begin
			case (step_q)
				teller_pkg::STEP_IDLE:
				begin
					cnt_q <= '0;
					if (start)
					begin
						account_q <= account;
						step_q <= teller_pkg::STEP_FETCH_TABLE;
					end
				end
				// Fetches take two cycles for the registered read
				teller_pkg::STEP_FETCH_TABLE, teller_pkg::STEP_FETCH_BAL:
				begin
					if (cnt_q == 3'd1)
					begin
						cnt_q <= '0;
						step_q <= (step_q == teller_pkg::STEP_FETCH_TABLE) ?
							teller_pkg::STEP_FETCH_BAL : teller_pkg::STEP_CHECK;
					end
					else
						cnt_q <= cnt_q + 3'd1;
				end
				teller_pkg::STEP_CHECK:
				begin
					cnt_q <= '0;
					if (check_done)
						step_q <= approved ? teller_pkg::STEP_WRITE : teller_pkg::STEP_TRAVEL;
				end
				teller_pkg::STEP_WRITE: step_q <= teller_pkg::STEP_TRAVEL;
				teller_pkg::STEP_TRAVEL:
				begin
					if (cnt_q == TRAVEL_LAST)
						step_q <= teller_pkg::STEP_DONE;
					else
						cnt_q <= cnt_q + 3'd1;
				end
				default: step_q <= teller_pkg::STEP_IDLE;
			endcase
		end
	end

	// RAM access decode from the current step
	always_comb
	begin
		case (step_q)
			teller_pkg::STEP_FETCH_TABLE: mem.access = teller_pkg::ACC_TABLE;
			teller_pkg::STEP_WRITE: mem.access = teller_pkg::ACC_LEDGER_WR;
			default: mem.access = teller_pkg::ACC_LEDGER_RD;
		endcase
	end

	assign mem.index = account_q;
	assign mem.wdata = new_balance;
	assign mem.wren = (step_q == teller_pkg::STEP_WRITE);

	assign step = step_q;
	assign travel = (step_q == teller_pkg::STEP_TRAVEL) ? cnt_q : 3'd0;
	assign finished = (step_q == teller_pkg::STEP_DONE);

	// Writes only follow an approved check
	write_after_approve: assert property (@(posedge clock) disable iff (!rst_n)
		mem.wren |-> $past(check_done && approved));

	finished_one_cycle: assert property (@(posedge clock) disable iff (!rst_n)
		finished |=> !finished);

endmodule

/* logic/verify_datapath.sv */
// Key and balance verification

`timescale 1ns/10ps

module verify_datapath (
	input logic clock,
	input logic rst_n,
	input teller_pkg::step_e step,
	ledger_mem_if.monitor mem,
	input teller_pkg::sw_word_u amount,
	input teller_pkg::sw_word_u key,
	output logic check_done,
	output logic approved,
	output logic [7:0] new_balance,
	output logic accepted,
	output logic [7:0] balance_out
);

	localparam int PIN_W = 8 - teller_pkg::ACCOUNT_W;

	teller_pkg::step_e prev_step_q;
	logic [7:0] table_q;
	logic [7:0] balance_q;
	logic second_cycle;
	logic pin_ok;
	logic funds_ok;

	always_ff @(posedge clock or negedge rst_n)
	begin
		if (!rst_n)
			prev_step_q <= teller_pkg::STEP_IDLE;
		else
			prev_step_q <= step;
	end

	// Read data is valid in the second cycle of a fetch
	assign second_cycle = (step == prev_step_q) &&
		(step == teller_pkg::STEP_FETCH_TABLE || step == teller_pkg::STEP_FETCH_BAL);

	always_ff @(posedge clock)
	begin
		if (second_cycle)
		begin
			case (mem.access)
				teller_pkg::ACC_TABLE: table_q <= mem.rdata;
				teller_pkg::ACC_LEDGER_RD: balance_q <= mem.rdata;
				default: ;
			endcase
		end
	end

	// Pin tag is checked against the low bits of the table word
	assign pin_ok = (key.key.pin == table_q[PIN_W-1:0]);
	assign funds_ok = (amount.amount <= balance_q);
	assign approved = pin_ok && funds_ok;
	assign new_balance = approved ? balance_q - amount.amount : balance_q;

	// Verdict settles within the check step
	assign check_done = (step == teller_pkg::STEP_CHECK);

	always_ff @(posedge clock or negedge rst_n)
	begin
		if (!rst_n)
		begin
			accepted <= 1'b0;
			balance_out <= '0;
		end
		else if (step == teller_pkg::STEP_DONE)
		begin
			accepted <= approved;
			balance_out <= new_balance;
		end
	end

	// Both words must have been fetched before the check
	fetched_before_check: assert property (@(posedge clock) disable iff (!rst_n)
		check_done |-> $past(step == teller_pkg::STEP_FETCH_BAL));

endmodule

/* logic/ledger_ram.sv */
// Table and ledger RAM

`timescale 1ns/10ps

`include "teller_defines.svh"

module ledger_ram (
	input logic clock,
	input logic rst_n,
	ledger_mem_if.ram mem
);

	localparam int ACCTS = `LEDGER_ACCOUNTS;
	localparam int DEPTH = 2 * ACCTS;
	localparam int ADDR_W = teller_pkg::ACCOUNT_W + 1;

	logic [7:0] mem_q [DEPTH];
	logic [ADDR_W-1:0] addr;

	// Table in the lower half, ledger in the upper half
	assign addr = {mem.access != teller_pkg::ACC_TABLE, mem.index};

	always_ff @(posedge clock or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < ACCTS; i++)
			begin
				mem_q[i] <= 8'(i * `TABLE_MULT + `TABLE_ADD);
				mem_q[i + ACCTS] <= 8'(`START_BALANCE);
			end
			mem.rdata <= '0;
		end
		else
		begin
			if (mem.wren)
				mem_q[addr] <= mem.wdata;
			mem.rdata <= mem_q[addr];
		end
	end

	// The table half is read only
	no_table_write: assert property (@(posedge clock) disable iff (!rst_n)
		mem.wren |-> mem.access == teller_pkg::ACC_LEDGER_WR);

endmodule

/* logic/teller_top.sv */
// Teller top level

`timescale 1ns/10ps

module teller_top (
	input logic clock,
	input logic rst_n,
	input logic [7:0] sw,
	input logic [1:0] key_n,
	output logic busy,
	output logic [2:0] step,
	output logic [2:0] travel,
	output logic finished,
	output logic accepted,
	output logic [7:0] balance_out
);

	logic start;
	logic check_done;
	logic approved;
	logic [7:0] new_balance;
	logic [teller_pkg::ACCOUNT_W-1:0] account;
	teller_pkg::sw_word_u amount;
	teller_pkg::sw_word_u key;
	teller_pkg::step_e step_s;

	ledger_mem_if mem_if ();

	main_control main_control_i (
		.clock(clock),
		.rst_n(rst_n),
		.key_n(key_n),
		.sw(sw),
		.finished(finished),
		.start(start),
		.amount(amount),
		.key(key),
		.account(account),
		.busy(busy),
		.ready()
	);

	transaction_control transaction_control_i (
		.clock(clock),
		.rst_n(rst_n),
		.start(start),
		.account(account),
		.check_done(check_done),
		.approved(approved),
		.new_balance(new_balance),
		.mem(mem_if.controller),
		.step(step_s),
		.travel(travel),
		.finished(finished)
	);

	verify_datapath verify_datapath_i (
		.clock(clock),
		.rst_n(rst_n),
		.step(step_s),
		.mem(mem_if.monitor),
		.amount(amount),
		.key(key),
		.check_done(check_done),
		.approved(approved),
		.new_balance(new_balance),
		.accepted(accepted),
		.balance_out(balance_out)
	);

	ledger_ram ledger_ram_i (
		.clock(clock),
		.rst_n(rst_n),
		.mem(mem_if.ram)
	);

	assign step = step_s;

endmodule

/* dv/teller_tb.sv */
// Teller directed testbench

`timescale 1ns/10ps

`include "teller_defines.svh"

module teller_tb;

	localparam int PIN_W = 8 - teller_pkg::ACCOUNT_W;
	localparam int START_KEY = 0;
	localparam int LOAD_KEY = 1;
	localparam int FINISH_TIMEOUT = 200;
	localparam int BUSY_TIMEOUT = 20;

	logic clock;
	logic rst_n;
	logic [7:0] sw;
	logic [1:0] key_n;
	logic busy;
	logic [2:0] step;
	logic [2:0] travel;
	logic finished;
	logic accepted;
	logic [7:0] balance_out;

	// Reference ledger
	logic [7:0] model_bal [`LEDGER_ACCOUNTS];
	logic [2:0] travel_seen [$];
	int seed;
	int check_count;
	int error_count;
	int test_errors;

	teller_top teller_top_i (
		.clock(clock),
		.rst_n(rst_n),
		.sw(sw),
		.key_n(key_n),
		.busy(busy),
		.step(step),
		.travel(travel),
		.finished(finished),
		.accepted(accepted),
		.balance_out(balance_out)
	);

	always #50 clock = ~clock;

	// Animation counts seen while travelling
	always @(negedge clock)
	begin
		if (rst_n && teller_pkg::step_e'(step) == teller_pkg::STEP_TRAVEL)
			travel_seen.push_back(travel);
	end

	task automatic compare_flag(input string what, input logic got, input logic exp);
		check_count++;
		if (got !== exp)
		begin
			error_count++;
			$display("Error at %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic compare_balance(input string what, input logic [7:0] got,
		input logic [7:0] exp);
		check_count++;
		if (got !== exp)
		begin
			error_count++;
			$display("Error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic compare_step(input string what, input teller_pkg::step_e got,
		input teller_pkg::step_e exp);
		check_count++;
		if (got !== exp)
		begin
			error_count++;
			$display("Error at %0t: %s is %s, expected %s", $time, what, got.name(), exp.name());
		end
	endtask

	task automatic compare_travel(input string what, input logic [2:0] got,
		input logic [2:0] exp);
		check_count++;
		if (got !== exp)
		begin
			error_count++;
			$display("Error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	// Secret table entry from the define rule
	function automatic logic [7:0] table_word(input int i);
		return 8'(i * `TABLE_MULT + `TABLE_ADD);
	endfunction

	function automatic logic [PIN_W-1:0] correct_pin(input logic [2:0] acct);
		logic [7:0] w;
		w = table_word(int'(acct));
		return w[PIN_W-1:0];
	endfunction

	// Expected verdict, and the model ledger follows an approved withdrawal
	task automatic predict(input logic [2:0] acct, input logic [7:0] amt,
		input logic [PIN_W-1:0] pin, output logic acc, output logic [7:0] bal);
		acc = (pin == correct_pin(acct)) && (amt <= model_bal[acct]);
		if (acc)
			model_bal[acct] = model_bal[acct] - amt;
		bal = model_bal[acct];
	endtask

	task automatic press(input int b);
		@(posedge clock);
		#1 key_n[b] = 1'b0;
		repeat (5) @(posedge clock);
		#1 key_n[b] = 1'b1;
		repeat (5) @(posedge clock);
	endtask

	task automatic wait_busy();
		int cycles;
		cycles = 0;
		@(negedge clock);
		while (busy !== 1'b1 && cycles < BUSY_TIMEOUT)
		begin
			@(negedge clock);
			cycles++;
		end
		if (busy !== 1'b1)
		begin
			$display("Timeout: the transaction never became busy after the start press");
			$display("TESTS FAILED");
			$finish;
		end
	endtask

	// Returns at the falling edge inside the finished cycle
	task automatic wait_finished();
		int cycles;
		cycles = 0;
		@(negedge clock);
		while (finished !== 1'b1 && cycles < FINISH_TIMEOUT)
		begin
			@(negedge clock);
			cycles++;
		end
		if (finished !== 1'b1)
		begin
			$display("Timeout: no finished pulse within %0d cycles", FINISH_TIMEOUT);
			$display("TESTS FAILED");
			$finish;
		end
	endtask

	task automatic do_transaction(input teller_pkg::sw_word_u amt_w,
		input teller_pkg::sw_word_u key_w);
		@(posedge clock);
		#1 sw = amt_w;
		press(LOAD_KEY);
		#1 sw = key_w;
		press(LOAD_KEY);
		press(START_KEY);
		wait_finished();
	endtask

	task automatic check_withdrawal(input string what, input logic [2:0] acct,
		input logic [7:0] amt, input logic [PIN_W-1:0] pin);
		teller_pkg::sw_word_u amt_w;
		teller_pkg::sw_word_u key_w;
		logic exp_acc;
		logic [7:0] exp_bal;
		amt_w.amount = amt;
		key_w.key.pin = pin;
		key_w.key.account = acct;
		do_transaction(amt_w, key_w);
		predict(acct, amt, pin, exp_acc, exp_bal);
		// Result registers load at the end of the done step
		@(negedge clock);
		compare_flag({what, " accepted"}, accepted, exp_acc);
		compare_balance({what, " balance_out"}, balance_out, exp_bal);
	endtask

	task automatic report_test(input string name);
		$display("Test %s finished with %0d errors", name, error_count - test_errors);
		test_errors = error_count;
	endtask

	initial
	begin
		logic [31:0] r;
		logic [2:0] acct;
		logic [7:0] amt;
		logic [PIN_W-1:0] pin;
		logic [PIN_W-1:0] flip;
		logic exp_acc;
		logic [7:0] exp_bal;
		teller_pkg::sw_word_u amt_w;
		teller_pkg::sw_word_u key_w;
		clock = 1'b0;
		rst_n = 1'b0;
		sw = '0;
		key_n = 2'b11;
		seed = 1;
		check_count = 0;
		error_count = 0;
		test_errors = 0;
		for (int i = 0; i < `LEDGER_ACCOUNTS; i++)
			model_bal[i] = 8'(`START_BALANCE);
		repeat (3) @(posedge clock);
		#1 rst_n = 1'b1;

		@(negedge clock);
		compare_flag("busy", busy, 1'b0);
		compare_flag("finished", finished, 1'b0);
		compare_flag("accepted", accepted, 1'b0);
		compare_step("step", teller_pkg::step_e'(step), teller_pkg::STEP_IDLE);
		compare_travel("travel", travel, 3'd0);
		report_test("reset_state");

		check_withdrawal("first", 3'd3, 8'd30, correct_pin(3'd3));
		compare_balance("first literal", balance_out, 8'd70);
		check_withdrawal("second", 3'd3, 8'd50, correct_pin(3'd3));
		compare_balance("second literal", balance_out, 8'd20);
		report_test("valid_withdrawal");

		check_withdrawal("wrong pin", 3'd1, 8'd10, correct_pin(3'd1) ^ 5'd1);
		report_test("wrong_pin");

		check_withdrawal("overdraft", 3'd3, model_bal[3] + 8'd1, correct_pin(3'd3));
		report_test("overdraft");

		// Presses during the transaction must not change its operands
		amt_w.amount = 8'd40;
		key_w.key.pin = correct_pin(3'd5);
		key_w.key.account = 3'd5;
		@(posedge clock);
		#1 sw = amt_w;
		press(LOAD_KEY);
		#1 sw = key_w;
		press(LOAD_KEY);
		travel_seen.delete();
		@(posedge clock);
		#1 key_n[START_KEY] = 1'b0;
		wait_busy();
		@(posedge clock);
		#1 key_n = 2'b11;
		sw = 8'hff;
		repeat (2) @(posedge clock);
		#1 key_n = 2'b00;
		repeat (4) @(posedge clock);
		#1 key_n = 2'b11;
		wait_finished();
		predict(3'd5, 8'd40, correct_pin(3'd5), exp_acc, exp_bal);
		@(negedge clock);
		compare_flag("busy press accepted", accepted, exp_acc);
		compare_balance("busy press balance_out", balance_out, exp_bal);
		compare_balance("busy press literal", balance_out, 8'd60);
		compare_flag("travel length", travel_seen.size() == `TRAVEL_LEN, 1'b1);
		for (int k = 0; k < travel_seen.size(); k++)
			compare_travel("travel count", travel_seen[k], 3'(k));
		compare_flag("busy after finish", busy, 1'b0);
		compare_step("step after finish", teller_pkg::step_e'(step), teller_pkg::STEP_IDLE);
		report_test("busy_presses");

		for (int n = 0; n < 20; n++)
		begin
			r = $random(seed);
			acct = r[2:0];
			amt = {2'b00, r[21:16]};
			pin = correct_pin(acct);
			// Wrong pin differs in one random bit
			if (r[8])
			begin
				flip = '0;
				flip[int'(r[12:10]) % PIN_W] = 1'b1;
				pin = pin ^ flip;
			end
			check_withdrawal("random", acct, amt, pin);
		end
		report_test("random_transactions");

		$display("Totals: %0d checks, %0d errors", check_count, error_count);
		if (error_count == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

/* all.f */
+incdir+include
logic/teller_pkg.sv
logic/ledger_mem_if.sv
logic/main_control.sv
logic/transaction_control.sv
logic/verify_datapath.sv
logic/ledger_ram.sv
logic/teller_top.sv
dv/teller_tb.sv

/* Makefile */
# Verilator build and run for the teller testbench

VERILATOR ?= verilator
TOP ?= teller_tb
FILELIST ?= all.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert
PASS_TEXT ?= TESTS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS PASS_TEXT"

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
